/* rtl/spi_slave_pkg.sv */
package spi_slave_pkg;

    //////////////////////////////////////////////////
    // spi framing

    // fixed byte width on the wire
    localparam int spi_byte_width = 8;

    typedef logic [spi_byte_width-1:0] spi_byte_t;

    // raw or filtered levels of the three input lines
    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_lines_t;

    // one-cycle pulses taken from the filtered levels
    typedef struct packed {
        logic sclk_rise;
        logic sclk_fall;
        // transfer start
        logic cs_fall;
        // transfer end
        logic cs_rise;
    } spi_events_t;

    //////////////////////////////////////////////////
    // default sizes for the top level

    localparam int default_data_width = 32;
    localparam int default_buf_size   = 6;
    // debounce length in clk cycles
    localparam int default_filter_div = 20;

endpackage

/* rtl/spi_line_filter.sv */
module spi_line_filter #(
    parameter int FILTER_DIV = spi_slave_pkg::default_filter_div
) (
    input  logic                        clk,
    input  logic                        rst,
    input  spi_slave_pkg::spi_lines_t   lines,
    output spi_slave_pkg::spi_lines_t   levels,
    output spi_slave_pkg::spi_events_t  events
);

    localparam int NUM_LINES = $bits(spi_slave_pkg::spi_lines_t);
    localparam int CNT_W     = $clog2(FILTER_DIV + 1);

    // bus idle: cs high, sclk low
    localparam spi_slave_pkg::spi_lines_t IDLE_LINES = '{cs: 1'b1, sclk: 1'b0, mosi: 1'b0};

    logic [NUM_LINES-1:0]      raw;
    logic [NUM_LINES-1:0]      filt;
    logic [CNT_W-1:0]          stable_cnt [NUM_LINES];
    spi_slave_pkg::spi_lines_t prev_levels;

    assign raw = lines;

    //////////////////////////////////////////////////
    // per-line debounce

    // count cycles the raw line disagrees with the filtered level
    always_ff @(posedge clk) begin
        if (rst) begin
            filt <= IDLE_LINES;
            for (int i = 0; i < NUM_LINES; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LINES; i++) begin
                if (raw[i] == filt[i]) begin
                    // any glitch back restarts the count
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(FILTER_DIV - 1)) begin
                    filt[i]       <= raw[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign levels = spi_slave_pkg::spi_lines_t'(filt);

    //////////////////////////////////////////////////
    // edge pulses

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_levels <= IDLE_LINES;
        end else begin
            prev_levels <= levels;
        end
    end

    assign events.sclk_rise =  levels.sclk & ~prev_levels.sclk;
    assign events.sclk_fall = ~levels.sclk &  prev_levels.sclk;
    assign events.cs_fall   = ~levels.cs   &  prev_levels.cs;
    assign events.cs_rise   =  levels.cs   & ~prev_levels.cs;

endmodule

/* rtl/spi_slave_phy.sv */
module spi_slave_phy (
    input  logic                        clk,
    input  logic                        rst,
    input  spi_slave_pkg::spi_lines_t   levels,
    input  spi_slave_pkg::spi_events_t  events,
    input  spi_slave_pkg::spi_byte_t    tx_byte,
    output logic                        byte_load,
    output spi_slave_pkg::spi_byte_t    rx_byte,
    output logic                        byte_done,
    output logic                        miso
);

    localparam int BYTE_W = spi_slave_pkg::spi_byte_width;
    localparam int BIT_W  = $clog2(BYTE_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(BYTE_W - 1);

    logic                     selected;
    logic                     rx_sample;
    logic [BIT_W-1:0]         rx_cnt;
    spi_slave_pkg::spi_byte_t rx_shift;
    logic [BIT_W-1:0]         tx_cnt;
    spi_slave_pkg::spi_byte_t tx_shift;
    logic                     tx_reload;

    assign selected  = ~levels.cs;
    assign rx_sample = events.sclk_rise & selected;

    //////////////////////////////////////////////////
    // receive side, mode 0 samples on rise

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_cnt    <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (events.cs_fall) begin
                rx_cnt <= '0;
            end else if (rx_sample) begin
                if (rx_cnt == LAST_BIT) begin
                    rx_cnt    <= '0;
                    byte_done <= 1'b1;
                end else begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clk) begin
        if (rx_sample) begin
            rx_shift <= {rx_shift[BYTE_W-2:0], levels.mosi};
        end
    end

    assign rx_byte = rx_shift;

    //////////////////////////////////////////////////
    // transmit side, mode 0 shifts on fall

    // first byte at select, then one per eight falls
    assign tx_reload = events.cs_fall
                     | (events.sclk_fall & selected & (tx_cnt == LAST_BIT));

    assign byte_load = tx_reload;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_shift <= '0;
            tx_cnt   <= '0;
        end else if (levels.cs) begin
            tx_shift <= '0;
            tx_cnt   <= '0;
        end else if (tx_reload) begin
            tx_shift <= tx_byte;
            tx_cnt   <= '0;
        end else if (events.sclk_fall) begin
            tx_shift <= tx_shift << 1;
            tx_cnt   <= tx_cnt + 1'b1;
        end
    end

    // line stays low while deselected
    assign miso = tx_shift[BYTE_W-1] & selected;

endmodule

/* rtl/word_buffer.sv */
module word_buffer #(
    parameter int DATA_WIDTH = spi_slave_pkg::default_data_width,
    parameter int BUF_SIZE   = spi_slave_pkg::default_buf_size
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  wr,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  rd,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  empty
);

    // pointers run 0..BUF_SIZE, no wrap
    localparam int PTR_W = $clog2(BUF_SIZE + 1);
    localparam logic [PTR_W-1:0] LIMIT = PTR_W'(BUF_SIZE);

    logic [DATA_WIDTH-1:0] mem [BUF_SIZE];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  full;
    logic                  do_wr;
    logic                  do_rd;

    assign full  = (wr_ptr == LIMIT);
    assign empty = (rd_ptr == wr_ptr);
    assign do_wr = wr & ~full & ~clear;
    assign do_rd = rd & ~empty & ~clear;

    //////////////////////////////////////////////////
    // pointers

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // storage

    // writes to a full store are dropped
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // zero once the words are used up
    always_comb begin
        data_out = '0;
        if (!empty) begin
            data_out = mem[rd_ptr];
        end
    end

endmodule

/* rtl/word_serializer.sv */
module word_serializer #(
    parameter int DATA_WIDTH = spi_slave_pkg::default_data_width
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     restart,
    input  logic [DATA_WIDTH-1:0]    word_in,
    input  logic                     byte_load,
    output logic                     pop,
    output spi_slave_pkg::spi_byte_t tx_byte
);

    localparam int BYTE_W = spi_slave_pkg::spi_byte_width;
    localparam int BYTES  = DATA_WIDTH / BYTE_W;
    localparam int IDX_W  = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BYTES - 1);

    // byte position inside the head word, 0 is the msb
    logic [IDX_W-1:0] idx;
    logic             last_byte;

    assign last_byte = (idx == LAST_IDX);

    //////////////////////////////////////////////////
    // byte position

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            idx <= '0;
        end else if (byte_load) begin
            if (last_byte) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // word is fully taken when its last byte is latched
    assign pop = byte_load & last_byte;

    //////////////////////////////////////////////////
    // byte select

    // msb first
    assign tx_byte = word_in[DATA_WIDTH - 1 - idx * BYTE_W -: BYTE_W];

endmodule

/* rtl/word_deserializer.sv */
module word_deserializer #(
    parameter int DATA_WIDTH = spi_slave_pkg::default_data_width
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     restart,
    input  logic                     byte_done,
    input  spi_slave_pkg::spi_byte_t rx_byte,
    output logic                     word_wr,
    output logic [DATA_WIDTH-1:0]    word_out
);

    localparam int BYTE_W = spi_slave_pkg::spi_byte_width;
    localparam int BYTES  = DATA_WIDTH / BYTE_W;
    localparam int CNT_W  = (BYTES > 1) ? $clog2(BYTES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BYTES - 1);

    logic [DATA_WIDTH-1:0] acc;
    logic [CNT_W-1:0]      cnt;

    // count bytes, flag the word on the last one
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            cnt     <= '0;
            word_wr <= 1'b0;
        end else begin
            word_wr <= 1'b0;
            if (byte_done) begin
                if (cnt == LAST_CNT) begin
                    cnt     <= '0;
                    word_wr <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // first byte ends up in the top
    always_ff @(posedge clk) begin
        if (byte_done) begin
            acc <= (acc << BYTE_W) | DATA_WIDTH'(rx_byte);
        end
    end

    assign word_out = acc;

endmodule

/* rtl/pu_slave_spi.sv */
module pu_slave_spi #(
    parameter int DATA_WIDTH = spi_slave_pkg::default_data_width,
    parameter int BUF_SIZE   = spi_slave_pkg::default_buf_size,
    parameter int FILTER_DIV = spi_slave_pkg::default_filter_div
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  signal_cycle,
    input  logic                  signal_wr,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  signal_oe,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  flag_stop,
    input  logic                  cs,
    input  logic                  sclk,
    input  logic                  mosi,
    output logic                  miso
);

    spi_slave_pkg::spi_lines_t  raw_lines;
    spi_slave_pkg::spi_lines_t  f_levels;
    spi_slave_pkg::spi_events_t f_events;
    spi_slave_pkg::spi_byte_t   tx_byte;
    spi_slave_pkg::spi_byte_t   rx_byte;
    logic                       byte_load;
    logic                       byte_done;
    logic                       pop;
    logic                       word_wr;
    logic [DATA_WIDTH-1:0]      word_out;
    logic [DATA_WIDTH-1:0]      bank0_out;
    logic [DATA_WIDTH-1:0]      bank1_out;
    logic                       bank0_empty;
    logic                       bank1_empty;
    logic                       recv_empty;
    logic [DATA_WIDTH-1:0]      read_word;
    logic                       read_empty;
    logic                       read_pop;
    logic                       swap;
    logic                       read_clear;
    // write bank index, the other bank feeds the wire
    logic                       bank_sel;

    assign raw_lines.cs   = cs;
    assign raw_lines.sclk = sclk;
    assign raw_lines.mosi = mosi;

    //////////////////////////////////////////////////
    // control

    // banks only swap between transfers
    assign swap       = signal_cycle & f_levels.cs;
    assign read_clear = swap | f_events.cs_rise;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_sel  <= 1'b0;
            flag_stop <= 1'b0;
        end else begin
            flag_stop <= f_events.cs_rise;
            if (swap) begin
                bank_sel <= ~bank_sel;
            end
        end
    end

    assign read_word  = bank_sel ? bank0_out : bank1_out;
    assign read_empty = bank_sel ? bank0_empty : bank1_empty;
    assign read_pop   = pop & ~read_empty;

    //////////////////////////////////////////////////
    // send path

    word_buffer #(.DATA_WIDTH(DATA_WIDTH), .BUF_SIZE(BUF_SIZE)) send_bank0 (
        .clk(clk), .rst(rst),
        .clear(read_clear & bank_sel),
        .wr(signal_wr & ~bank_sel), .data_in(data_in),
        .rd(read_pop & bank_sel),
        .data_out(bank0_out), .empty(bank0_empty)
    );

    word_buffer #(.DATA_WIDTH(DATA_WIDTH), .BUF_SIZE(BUF_SIZE)) send_bank1 (
        .clk(clk), .rst(rst),
        .clear(read_clear & ~bank_sel),
        .wr(signal_wr & bank_sel), .data_in(data_in),
        .rd(read_pop & ~bank_sel),
        .data_out(bank1_out), .empty(bank1_empty)
    );

    word_serializer #(.DATA_WIDTH(DATA_WIDTH)) serializer (
        .clk(clk), .rst(rst), .restart(f_events.cs_rise),
        .word_in(read_word), .byte_load(byte_load),
        .pop(pop), .tx_byte(tx_byte)
    );

    //////////////////////////////////////////////////
    // spi lines

    spi_line_filter #(.FILTER_DIV(FILTER_DIV)) line_filter (
        .clk(clk), .rst(rst), .lines(raw_lines),
        .levels(f_levels), .events(f_events)
    );

    spi_slave_phy phy (
        .clk(clk), .rst(rst), .levels(f_levels), .events(f_events),
        .tx_byte(tx_byte), .byte_load(byte_load),
        .rx_byte(rx_byte), .byte_done(byte_done), .miso(miso)
    );

    //////////////////////////////////////////////////
    // receive path

    // a partial word is dropped at transfer end
    word_deserializer #(.DATA_WIDTH(DATA_WIDTH)) deserializer (
        .clk(clk), .rst(rst), .restart(f_events.cs_rise),
        .byte_done(byte_done), .rx_byte(rx_byte),
        .word_wr(word_wr), .word_out(word_out)
    );

    word_buffer #(.DATA_WIDTH(DATA_WIDTH), .BUF_SIZE(BUF_SIZE)) recv_store (
        .clk(clk), .rst(rst),
        .clear(f_events.cs_fall),
        .wr(word_wr), .data_in(word_out),
        .rd(signal_oe & ~recv_empty),
        .data_out(data_out), .empty(recv_empty)
    );

endmodule

/* sim/pu_slave_spi_checker.sv */
module pu_slave_spi_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       flag_stop,
    input logic                       miso,
    input spi_slave_pkg::spi_events_t events
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench
    int fail_count = 0;

    // stop flag is a single pulse
    stop_single_pulse: assert property (
        @(posedge clk) disable iff (rst) flag_stop |=> !flag_stop
    ) else begin
        fail_count++;
        $error("flag_stop stayed high for two cycles");
    end

    // reset leaves the outputs low
    reset_outputs_low: assert property (
        @(posedge clk) rst |=> (!flag_stop && !miso)
    ) else begin
        fail_count++;
        $error("flag_stop or miso high after reset");
    end

    // miso moves only after a load or shift, or drops at deselect
    miso_shift_timing: assert property (
        @(posedge clk) disable iff (rst)
        $changed(miso) |-> ($past(events.sclk_fall || events.cs_fall) || events.cs_rise)
    ) else begin
        fail_count++;
        $error("miso changed outside a load, shift or deselect");
    end

endmodule

bind pu_slave_spi pu_slave_spi_checker control_checks (
    .clk(clk), .rst(rst), .flag_stop(flag_stop), .miso(miso), .events(f_events)
);

/* sim/pu_slave_spi_tb.sv */
module pu_slave_spi_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH = 32;
    localparam int BUF_SIZE   = 6;
    localparam int FILTER_DIV = 3;
    localparam int BYTE_W     = spi_slave_pkg::spi_byte_width;
    localparam int WORD_BYTES = DATA_WIDTH / BYTE_W;
    // sclk half period in clk cycles
    localparam int HALF       = 16;
    localparam int NUM_XFERS  = 20;
    // full store plus one partial word
    localparam int MAX_BYTES  = BUF_SIZE * WORD_BYTES + WORD_BYTES;
    localparam int STOP_WAIT  = 4 * FILTER_DIV + 8;
    // every transfer at full length, plus writes, reads and reset
    localparam int CYCLE_LIMIT = NUM_XFERS * (MAX_BYTES * BYTE_W * 2 * HALF + 400) + 1000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  signal_cycle;
    logic                  signal_wr;
    logic [DATA_WIDTH-1:0] data_in;
    logic                  signal_oe;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  flag_stop;
    logic                  cs;
    logic                  sclk;
    logic                  mosi;
    logic                  miso;

    integer seed = 32'h9052b290;
    int     cycle_count = 0;
    int     stop_count = 0;
    int     stops_expected = 0;

    // reference model of the two send banks and the receive store
    logic [DATA_WIDTH-1:0] bank_mem [2][BUF_SIZE];
    int                    bank_cnt [2];
    int                    model_sel = 0;
    logic [DATA_WIDTH-1:0] rx_q [$];

    pu_slave_spi #(
        .DATA_WIDTH(DATA_WIDTH), .BUF_SIZE(BUF_SIZE), .FILTER_DIV(FILTER_DIV)
    ) uut (
        .clk(clk), .rst(rst), .signal_cycle(signal_cycle), .signal_wr(signal_wr),
        .data_in(data_in), .signal_oe(signal_oe), .data_out(data_out),
        .flag_stop(flag_stop), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (flag_stop) begin
            stop_count++;
        end
        if (uut.control_checks.fail_count != 0) begin
            $display("a bound assertion on the control outputs failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                               input logic [DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %0h, expected %0h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // inputs change shortly after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic write_word(input logic [DATA_WIDTH-1:0] word);
        signal_wr = 1'b1;
        data_in   = word;
        step(1);
        signal_wr = 1'b0;
        // full bank drops the word
        if (bank_cnt[model_sel] < BUF_SIZE) begin
            bank_mem[model_sel][bank_cnt[model_sel]] = word;
            bank_cnt[model_sel]++;
        end
    endtask

    task automatic swap_banks();
        signal_cycle = 1'b1;
        step(1);
        signal_cycle = 1'b0;
        // old read bank becomes the cleared write bank
        bank_cnt[1 - model_sel] = 0;
        model_sel = 1 - model_sel;
    endtask

    //////////////////////////////////////////////////
    // spi master

    task automatic run_transfer(input int nbytes, input int mid_writes);
        int                    rd_bank;
        int                    waited;
        int                    glitch_len;
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] acc;
        logic [BYTE_W-1:0]     tx_exp;
        logic [BYTE_W-1:0]     mosi_byte;
        logic [BYTE_W-1:0]     miso_byte;
        rd_bank = 1 - model_sel;
        acc = '0;
        check_value("flag_stop pulses", DATA_WIDTH'(stop_count), DATA_WIDTH'(stops_expected));
        rx_q.delete();
        cs = 1'b0;
        // these land in the write bank only
        repeat (mid_writes) write_word($random(seed));
        for (int b = 0; b < nbytes; b++) begin
            word = (b / WORD_BYTES < bank_cnt[rd_bank]) ? bank_mem[rd_bank][b / WORD_BYTES] : '0;
            tx_exp = BYTE_W'(word >> (BYTE_W * (WORD_BYTES - 1 - b % WORD_BYTES)));
            mosi_byte = BYTE_W'($random(seed));
            for (int i = BYTE_W - 1; i >= 0; i--) begin
                mosi = mosi_byte[i];
                if (rand_range(0, 3) == 0) begin
                    // short sclk spike the filter must reject
                    glitch_len = rand_range(1, FILTER_DIV - 1);
                    step(5);
                    sclk = 1'b1;
                    step(glitch_len);
                    sclk = 1'b0;
                    step(HALF - 5 - glitch_len);
                end else begin
                    step(HALF);
                end
                miso_byte[i] = miso;
                sclk = 1'b1;
                step(HALF);
                sclk = 1'b0;
            end
            check_value("miso byte", DATA_WIDTH'(miso_byte), DATA_WIDTH'(tx_exp));
            acc = (acc << BYTE_W) | DATA_WIDTH'(mosi_byte);
            if (b % WORD_BYTES == WORD_BYTES - 1 && rx_q.size() < BUF_SIZE) begin
                rx_q.push_back(acc);
            end
        end
        step(HALF);
        stop_count = 0;
        cs = 1'b1;
        waited = 0;
        while (stop_count == 0 && waited < STOP_WAIT) begin
            step(1);
            waited++;
        end
        check_value("flag_stop", DATA_WIDTH'(stop_count), 1);
        step(2);
        bank_cnt[rd_bank] = 0;
        stops_expected = 1;
    endtask

    task automatic read_received();
        while (rx_q.size() > 0) begin
            check_value("data_out", data_out, rx_q.pop_front());
            signal_oe = 1'b1;
            step(1);
            signal_oe = 1'b0;
        end
        check_value("data_out", data_out, '0);
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        rst = 1'b1;
        signal_cycle = 1'b0;
        signal_wr = 1'b0;
        data_in = '0;
        signal_oe = 1'b0;
        cs = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        bank_cnt[0] = 0;
        bank_cnt[1] = 0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        check_value("data_out", data_out, '0);
        check_value("flag_stop", DATA_WIDTH'(flag_stop), '0);
        check_value("miso", DATA_WIDTH'(miso), '0);
        for (int t = 0; t < NUM_XFERS; t++) begin
            repeat (rand_range(1, BUF_SIZE)) write_word($random(seed));
            swap_banks();
            run_transfer(rand_range(1, MAX_BYTES), rand_range(0, 2));
            read_received();
        end
        check_value("flag_stop pulses", DATA_WIDTH'(stop_count), 1);
        if (uut.control_checks.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

/* vlog.f */
rtl/spi_slave_pkg.sv
rtl/spi_line_filter.sv
rtl/spi_slave_phy.sv
rtl/word_buffer.sv
rtl/word_serializer.sv
rtl/word_deserializer.sv
rtl/pu_slave_spi.sv
sim/pu_slave_spi_checker.sv
sim/pu_slave_spi_tb.sv
